/* common/bp_config.svh */
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// buffer depths, both powers of two
`define BTB_ENTRIES 8
`define JTB_ENTRIES 4

// history shift registers and prediction thresholds
`define HIST_BITS   10
`define HIST_STRONG 896
`define HIST_WEAK   16
`define MISS_LIMIT  848

`define RESET_PC 32'h0000_0000

`endif

/* common/bp_pkg.sv */
package bp_pkg;

    typedef logic [31:0] rv32i_word;

    // rv32i major opcodes seen by the predictor
    typedef enum logic [6:0] {
        op_br    = 7'b1100011,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_imm   = 7'b0010011,
        op_other = 7'b0000000
    } rv32i_opcode;

    // resolution of the instruction sitting in execute
    typedef struct packed {
        logic        valid;
        logic        stall;        // instruction stays in execute next cycle
        rv32i_opcode opcode;
        rv32i_word   pc;
        rv32i_word   target;       // computed jump target
        rv32i_word   bimm;         // branch offset, bits 12:1 used
        logic        taken;        // actual outcome
        logic        pred_taken;   // what fetch predicted for this pc
        rv32i_word   pred_target;
    } exe_resolve_t;

    // fetch pc together with its prediction
    typedef struct packed {
        rv32i_word pc;
        logic      pred_taken;
        rv32i_word pred_target;
    } fetch_pred_t;

endpackage : bp_pkg

/* predictor/btb_entry.sv */
`include "bp_config.svh"

module btb_entry
    import bp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        update_pc,        // allocate this entry
    input  logic        update_history,   // shift in a new outcome
    input  logic        taken,
    input  logic        pred_taken,
    input  rv32i_word   pc_exe,
    input  rv32i_word   pc_fetch,
    input  logic [11:0] offset,
    output logic        fetch_hit,
    output logic        exe_hit,
    output logic        prediction,
    output rv32i_word   target
);

    localparam logic [`HIST_BITS-1:0] hist_strong = `HIST_STRONG;
    localparam logic [`HIST_BITS-1:0] hist_weak   = `HIST_WEAK;
    localparam logic [`HIST_BITS-1:0] miss_limit  = `MISS_LIMIT;

    logic                  valid;
    rv32i_word             entry_pc;
    logic [11:0]           entry_offset;
    logic [`HIST_BITS-1:0] taken_hist;   // msb is the most recent outcome
    logic [`HIST_BITS-1:0] pred_hist;

    assign fetch_hit = valid && (pc_fetch == entry_pc);
    assign exe_hit   = valid && (pc_exe == entry_pc);
    assign target    = entry_pc + {{19{entry_offset[11]}}, entry_offset, 1'b0};

    always_comb begin
        if (taken_hist >= hist_strong) begin
            prediction = 1'b1;
        end else if (taken_hist < hist_weak) begin
            prediction = 1'b0;
        end else if ((taken_hist ^ pred_hist) >= miss_limit) begin
            prediction = ~pred_hist[`HIST_BITS-1];   // recent guesses were poor
        end else begin
            prediction = pred_hist[`HIST_BITS-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (update_pc) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update_pc) begin
            entry_pc     <= pc_exe;
            entry_offset <= offset;
            taken_hist   <= {1'b1, {(`HIST_BITS-1){1'b0}}};   // seen taken once
            pred_hist    <= '0;
        end else if (update_history) begin
            taken_hist <= {taken, taken_hist[`HIST_BITS-1:1]};
            pred_hist  <= {pred_taken, pred_hist[`HIST_BITS-1:1]};
        end
    end

endmodule : btb_entry

/* predictor/jtb_entry.sv */
module jtb_entry
    import bp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      update_pc,
    input  rv32i_word pc_exe,
    input  rv32i_word pc_fetch,
    input  rv32i_word jump_target,
    output logic      fetch_hit,
    output logic      exe_hit,
    output rv32i_word target
);

    logic      valid;
    rv32i_word entry_pc;
    rv32i_word entry_target;

    assign fetch_hit = valid && (pc_fetch == entry_pc);
    assign exe_hit   = valid && (pc_exe == entry_pc);
    assign target    = entry_target;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (update_pc) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update_pc) begin
            entry_pc     <= pc_exe;
            entry_target <= jump_target;
        end
    end

endmodule : jtb_entry

/* predictor/control_buffer.sv */
`include "bp_config.svh"

module control_buffer
    import bp_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         sel,          // first cycle of a valid instruction in execute
    input  exe_resolve_t exe,
    input  rv32i_word    pc_fetch,
    output logic         prediction,
    output rv32i_word    target
);

    localparam int btb_idx_w = $clog2(`BTB_ENTRIES);
    localparam int jtb_idx_w = $clog2(`JTB_ENTRIES);

    logic [`BTB_ENTRIES-1:0] btb_fetch_hits;
    logic [`BTB_ENTRIES-1:0] btb_exe_hits;
    logic [`BTB_ENTRIES-1:0] btb_preds;
    logic [`BTB_ENTRIES-1:0] btb_load;
    logic [`BTB_ENTRIES-1:0] btb_shift;
    rv32i_word               btb_targets [`BTB_ENTRIES];

    logic [`JTB_ENTRIES-1:0] jtb_fetch_hits;
    logic [`JTB_ENTRIES-1:0] jtb_exe_hits;
    logic [`JTB_ENTRIES-1:0] jtb_load;
    rv32i_word               jtb_targets [`JTB_ENTRIES];

    logic [btb_idx_w-1:0] btb_head;
    logic [btb_idx_w-1:0] btb_fetch_idx;
    logic [btb_idx_w-1:0] btb_exe_idx;
    logic [jtb_idx_w-1:0] jtb_head;
    logic [jtb_idx_w-1:0] jtb_fetch_idx;

    for (genvar i = 0; i < `BTB_ENTRIES; i++) begin : g_btb
        btb_entry u_entry (
            .clk            (clk),
            .rst            (rst),
            .update_pc      (btb_load[i]),
            .update_history (btb_shift[i]),
            .taken          (exe.taken),
            .pred_taken     (exe.pred_taken),
            .pc_exe         (exe.pc),
            .pc_fetch       (pc_fetch),
            .offset         (exe.bimm[12:1]),
            .fetch_hit      (btb_fetch_hits[i]),
            .exe_hit        (btb_exe_hits[i]),
            .prediction     (btb_preds[i]),
            .target         (btb_targets[i])
        );
    end

    for (genvar j = 0; j < `JTB_ENTRIES; j++) begin : g_jtb
        jtb_entry u_entry (
            .clk         (clk),
            .rst         (rst),
            .update_pc   (jtb_load[j]),
            .pc_exe      (exe.pc),
            .pc_fetch    (pc_fetch),
            .jump_target (exe.target),
            .fetch_hit   (jtb_fetch_hits[j]),
            .exe_hit     (jtb_exe_hits[j]),
            .target      (jtb_targets[j])
        );
    end

    // a pc is allocated only on a miss, so hits stay one-hot
    always_comb begin
        btb_fetch_idx = '0;
        btb_exe_idx   = '0;
        jtb_fetch_idx = '0;
        for (int k = 0; k < `BTB_ENTRIES; k++) begin
            if (btb_fetch_hits[k]) btb_fetch_idx = btb_idx_w'(k);
            if (btb_exe_hits[k])   btb_exe_idx   = btb_idx_w'(k);
        end
        for (int k = 0; k < `JTB_ENTRIES; k++) begin
            if (jtb_fetch_hits[k]) jtb_fetch_idx = jtb_idx_w'(k);
        end
    end

    always_comb begin
        btb_load  = '0;
        btb_shift = '0;
        jtb_load  = '0;
        if (sel) begin
            if (exe.opcode == op_br) begin
                if (|btb_exe_hits) begin
                    btb_shift[btb_exe_idx] = 1'b1;   // known branch, train it
                end else if (exe.taken) begin
                    btb_load[btb_head] = 1'b1;       // replace oldest entry
                end
            end else if (exe.opcode == op_jal && !(|jtb_exe_hits) && exe.taken) begin
                jtb_load[jtb_head] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            btb_head <= '0;
            jtb_head <= '0;
        end else begin
            if (|btb_load) btb_head <= btb_head + 1'b1;   // wraps, depth is a power of two
            if (|jtb_load) jtb_head <= jtb_head + 1'b1;
        end
    end

    // fetch side lookup with branch buffer first
    always_comb begin
        if (|btb_fetch_hits) begin
            prediction = btb_preds[btb_fetch_idx];
            target     = btb_targets[btb_fetch_idx];
        end else if (|jtb_fetch_hits) begin
            prediction = 1'b1;
            target     = jtb_targets[jtb_fetch_idx];
        end else begin
            prediction = 1'b0;
            target     = 32'hff;   // no target known
        end
    end

endmodule : control_buffer

/* hdl/resolve_capture.sv */
module resolve_capture
    import bp_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  exe_resolve_t exe,
    output logic         sel,
    output logic         redirect,
    output rv32i_word    redirect_pc
);

    logic      held;          // same instruction still in execute
    logic      mispredict;
    rv32i_word taken_pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
        end else begin
            held <= exe.valid && exe.stall;
        end
    end

    assign sel = exe.valid && !held;

    always_comb begin
        if (exe.opcode == op_br) begin
            taken_pc = exe.pc + {{19{exe.bimm[12]}}, exe.bimm[12:1], 1'b0};
        end else begin
            taken_pc = exe.target;
        end
    end

    assign redirect_pc = exe.taken ? taken_pc : exe.pc + 32'd4;

    // wrong direction, or right direction but wrong target
    assign mispredict = (exe.taken != exe.pred_taken) ||
                        (exe.taken && (exe.pred_target != taken_pc));

    assign redirect = sel && mispredict;

endmodule : resolve_capture

/* hdl/next_pc_select.sv */
`include "bp_config.svh"

module next_pc_select
    import bp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_stall,
    input  logic        redirect,
    input  rv32i_word   redirect_pc,
    input  logic        prediction,    // lookup result for the current pc
    input  rv32i_word   pred_target,
    output fetch_pred_t fetch
);

    rv32i_word pc;
    rv32i_word pc_next;

    // a redirect wins over a stalled fetch
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (fetch_stall) begin
            pc_next = pc;
        end else if (prediction) begin
            pc_next = pred_target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign fetch.pc          = pc;
    assign fetch.pred_taken  = prediction;
    assign fetch.pred_target = pred_target;

endmodule : next_pc_select

/* hdl/branch_predict_top.sv */
module branch_predict_top
    import bp_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  exe_resolve_t exe,
    input  logic         fetch_stall,
    output fetch_pred_t  fetch,
    output logic         redirect
);

    logic      sel;
    logic      prediction;
    rv32i_word redirect_pc;
    rv32i_word pred_target;

    resolve_capture u_resolve (
        .clk         (clk),
        .rst         (rst),
        .exe         (exe),
        .sel         (sel),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    control_buffer u_buffer (
        .clk        (clk),
        .rst        (rst),
        .sel        (sel),
        .exe        (exe),
        .pc_fetch   (fetch.pc),   // lookup on the registered fetch pc
        .prediction (prediction),
        .target     (pred_target)
    );

    next_pc_select u_next_pc (
        .clk         (clk),
        .rst         (rst),
        .fetch_stall (fetch_stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .prediction  (prediction),
        .pred_target (pred_target),
        .fetch       (fetch)
    );

endmodule : branch_predict_top

/* tb/branch_predict_assert.sv */
module branch_predict_assert
    import bp_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input exe_resolve_t exe,
    input logic         fetch_stall,
    input fetch_pred_t  fetch,
    input logic         redirect
);

    redirect_needs_valid: assert property (@(posedge clk) disable iff (rst)
        redirect |-> exe.valid)
        else $error("redirect raised with no valid instruction in execute");

    stall_holds_pc: assert property (@(posedge clk) disable iff (rst)
        (fetch_stall && !redirect) |=> $stable(fetch.pc))
        else $error("fetch pc moved under fetch_stall without a redirect");

endmodule : branch_predict_assert

bind branch_predict_top branch_predict_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .exe         (exe),
    .fetch_stall (fetch_stall),
    .fetch       (fetch),
    .redirect    (redirect)
);

/* tb/branch_predict_tb.sv */
`include "bp_config.svh"

module branch_predict_tb
    import bp_pkg::*;
();

    localparam int max_cycles = 2000;   // all six tests need well under 400 cycles

    logic         clk;
    logic         rst;
    exe_resolve_t exe;
    logic         fetch_stall;
    fetch_pred_t  fetch;
    logic         redirect;

    int checks = 0;
    int errors = 0;
    int cycles_run = 0;

    // reference copy of both buffers
    logic                  btb_valid [`BTB_ENTRIES];
    rv32i_word             btb_pc    [`BTB_ENTRIES];
    logic [11:0]           btb_off   [`BTB_ENTRIES];
    logic [`HIST_BITS-1:0] btb_th    [`BTB_ENTRIES];
    logic [`HIST_BITS-1:0] btb_ph    [`BTB_ENTRIES];
    int                    btb_head;
    logic                  jtb_valid [`JTB_ENTRIES];
    rv32i_word             jtb_pc    [`JTB_ENTRIES];
    rv32i_word             jtb_tgt   [`JTB_ENTRIES];
    int                    jtb_head;

    branch_predict_top uut (
        .clk         (clk),
        .rst         (rst),
        .exe         (exe),
        .fetch_stall (fetch_stall),
        .fetch       (fetch),
        .redirect    (redirect)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles_run++;
        if (cycles_run >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic compare_fetch(input string name, input fetch_pred_t expected,
                                 input fetch_pred_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected pc %h taken %b target %h, got pc %h taken %b target %h",
                     name, expected.pc, expected.pred_taken, expected.pred_target,
                     actual.pc, actual.pred_taken, actual.pred_target);
        end
    endtask

    task automatic expect_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %b, got %b", name, expected, actual);
        end
    endtask

    function automatic rv32i_word branch_target(input rv32i_word pc, input logic [11:0] off);
        return pc + {{19{off[11]}}, off, 1'b0};
    endfunction

    function automatic logic threshold_predict(input logic [`HIST_BITS-1:0] h,
                                               input logic [`HIST_BITS-1:0] p);
        if (int'(h) >= `HIST_STRONG)
            return 1'b1;
        else if (int'(h) < `HIST_WEAK)
            return 1'b0;
        else if (int'(h ^ p) >= `MISS_LIMIT)
            return ~p[`HIST_BITS-1];
        else
            return p[`HIST_BITS-1];
    endfunction

    // btb is scanned last so a branch hit overrides a jump hit
    function automatic fetch_pred_t expected_fetch(input rv32i_word pc);
        fetch_pred_t f;
        f.pc          = pc;
        f.pred_taken  = 1'b0;
        f.pred_target = 32'hff;
        for (int j = 0; j < `JTB_ENTRIES; j++) begin
            if (jtb_valid[j] && jtb_pc[j] == pc) begin
                f.pred_taken  = 1'b1;
                f.pred_target = jtb_tgt[j];
            end
        end
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            if (btb_valid[i] && btb_pc[i] == pc) begin
                f.pred_taken  = threshold_predict(btb_th[i], btb_ph[i]);
                f.pred_target = branch_target(btb_pc[i], btb_off[i]);
            end
        end
        return f;
    endfunction

    task automatic model_update(input rv32i_opcode op, input rv32i_word pc,
                                input rv32i_word target, input logic [11:0] off,
                                input logic taken, input logic pred_taken);
        int hit;
        hit = -1;
        if (op == op_br) begin
            for (int i = 0; i < `BTB_ENTRIES; i++)
                if (btb_valid[i] && btb_pc[i] == pc)
                    hit = i;
            if (hit >= 0) begin
                btb_th[hit] = {taken, btb_th[hit][`HIST_BITS-1:1]};
                btb_ph[hit] = {pred_taken, btb_ph[hit][`HIST_BITS-1:1]};
            end else if (taken) begin
                btb_valid[btb_head] = 1'b1;
                btb_pc[btb_head]    = pc;
                btb_off[btb_head]   = off;
                btb_th[btb_head]    = {1'b1, {(`HIST_BITS-1){1'b0}}};
                btb_ph[btb_head]    = '0;
                btb_head            = (btb_head + 1) % `BTB_ENTRIES;
            end
        end else if (op == op_jal && taken) begin
            for (int j = 0; j < `JTB_ENTRIES; j++)
                if (jtb_valid[j] && jtb_pc[j] == pc)
                    hit = j;
            if (hit < 0) begin
                jtb_valid[jtb_head] = 1'b1;
                jtb_pc[jtb_head]    = pc;
                jtb_tgt[jtb_head]   = target;
                jtb_head            = (jtb_head + 1) % `JTB_ENTRIES;
            end
        end
    endtask

    // holds one instruction in execute for the given number of cycles
    task automatic resolve(input string name, input rv32i_opcode op, input rv32i_word pc,
                           input rv32i_word target, input rv32i_word bimm, input logic taken,
                           input logic pred_taken, input rv32i_word pred_target,
                           input int cycles);
        rv32i_word    actual_target;
        rv32i_word    next_pc;
        logic         mispredict;
        exe_resolve_t r;
        actual_target = (op == op_br) ? branch_target(pc, bimm[12:1]) : target;
        next_pc       = taken ? actual_target : pc + 32'd4;
        mispredict    = (taken != pred_taken) || (taken && pred_target != actual_target);
        r             = '0;
        r.valid       = 1'b1;
        r.opcode      = op;
        r.pc          = pc;
        r.target      = target;
        r.bimm        = bimm;
        r.taken       = taken;
        r.pred_taken  = pred_taken;
        r.pred_target = pred_target;
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            #1;
            r.stall = (c < cycles - 1);
            exe     = r;
            @(negedge clk);
            expect_bit({name, " redirect"}, (c == 0) && mispredict, redirect);
            if (c == 0)
                model_update(op, pc, target, bimm[12:1], taken, pred_taken);
            if (c == 1 && mispredict)
                compare_fetch(name, expected_fetch(next_pc), fetch);
        end
        @(posedge clk);
        #1;
        exe = '0;
        @(negedge clk);
        if (cycles == 1 && mispredict)
            compare_fetch(name, expected_fetch(next_pc), fetch);
    endtask

    // steer fetch to pc with a non-buffered instruction, then check the lookup there
    task automatic look(input string name, input rv32i_word pc);
        resolve(name, op_imm, 32'h0000_0ff0, pc, 32'h0, 1'b1, 1'b0, 32'h0, 1);
    endtask

    // let fetch run for one edge so it takes the predicted target
    task automatic follow_prediction(input string name, input rv32i_word next_pc);
        @(posedge clk);
        #1;
        fetch_stall = 1'b0;
        @(posedge clk);
        #1;
        fetch_stall = 1'b1;
        @(negedge clk);
        compare_fetch(name, expected_fetch(next_pc), fetch);
    endtask

    task automatic sequential_fetch();
        rv32i_word pc;
        pc = `RESET_PC;
        @(negedge clk);
        compare_fetch("reset pc", expected_fetch(pc), fetch);
        @(posedge clk);
        #1;
        fetch_stall = 1'b0;
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            #1;
            if (i == 5)
                fetch_stall = 1'b1;
            @(negedge clk);
            pc = pc + 32'd4;
            compare_fetch("sequential step", expected_fetch(pc), fetch);
        end
        repeat (3) begin
            @(negedge clk);
            compare_fetch("stalled fetch", expected_fetch(pc), fetch);
        end
    endtask

    task automatic jump_learning();
        resolve("jal first", op_jal, 32'h100, 32'h2000, 32'h0, 1'b1, 1'b0, 32'hff, 1);
        look("jal learned", 32'h100);
        expect_bit("jal predicted taken", 1'b1, fetch.pred_taken);
        follow_prediction("jal followed", 32'h2000);
        resolve("jal hit", op_jal, 32'h100, 32'h2000, 32'h0, 1'b1, 1'b1, 32'h2000, 1);
        for (int i = 1; i < 5; i++)
            resolve("jal fill", op_jal, 32'h100 + 32'(4 * i), 32'h2000 + 32'(256 * i),
                    32'h0, 1'b1, 1'b0, 32'hff, 1);
        for (int i = 0; i < 5; i++)
            look("jal after eviction", 32'h100 + 32'(4 * i));
    endtask

    task automatic branch_histories();
        rv32i_word   pc;
        rv32i_word   bimm;
        rv32i_word   rnd;
        fetch_pred_t guess;
        logic        outcome;
        pc   = 32'h0001_0000 | ($urandom & 32'h0000_fffc);
        bimm = $urandom & 32'h0000_1ffe;
        for (int i = 0; i < 24; i++) begin
            rnd     = $urandom;
            guess   = expected_fetch(pc);           // what fetch carried for this branch
            outcome = (i == 0) ? 1'b1 : rnd[7];
            resolve("branch history", op_br, pc, 32'h0, bimm, outcome,
                    guess.pred_taken, guess.pred_target, 1);
            look("branch history lookup", pc);
        end
    endtask

    task automatic mispredict_redirect();
        resolve("taken, guessed not taken", op_br, 32'h4000, 32'h0, 32'h40, 1'b1, 1'b0,
                32'hff, 1);
        resolve("not taken, guessed taken", op_br, 32'h4000, 32'h0, 32'h40, 1'b0, 1'b1,
                32'h4040, 1);
        resolve("wrong target", op_br, 32'h4000, 32'h0, 32'h40, 1'b1, 1'b1, 32'h4080, 1);
        resolve("correct taken", op_br, 32'h4000, 32'h0, 32'h40, 1'b1, 1'b1, 32'h4040, 1);
        resolve("correct not taken", op_br, 32'h4000, 32'h0, 32'h40, 1'b0, 1'b0, 32'hff, 1);
        resolve("backward branch", op_br, 32'h4100, 32'h0, 32'h1ff0, 1'b1, 1'b0, 32'hff, 1);
        resolve("jal wrong target", op_jal, 32'h4200, 32'h5000, 32'h0, 1'b1, 1'b1,
                32'h5004, 1);
    endtask

    // one or two shifts of this pattern give opposite predictions
    task automatic stall_holding();
        resolve("stall allocate", op_br, 32'h4400, 32'h0, 32'h20, 1'b1, 1'b0, 32'hff, 1);
        resolve("stalled branch", op_br, 32'h4400, 32'h0, 32'h20, 1'b0, 1'b1, 32'h4420, 4);
        look("single history update", 32'h4400);
    endtask

    task automatic btb_eviction();
        rv32i_word pcs [9];
        rv32i_word offs [9];
        for (int i = 0; i < 9; i++) begin
            pcs[i]  = 32'h0002_0000 + 32'(i * 256) + ($urandom & 32'h0000_00fc);
            offs[i] = $urandom & 32'h0000_1ffe;
            resolve("btb fill", op_br, pcs[i], 32'h0, offs[i], 1'b1, 1'b0, 32'hff, 1);
        end
        look("btb oldest evicted", pcs[0]);
        expect_bit("btb oldest has no target", 1'b1, fetch.pred_target == 32'hff);
        for (int i = 1; i < 9; i++)
            look("btb entry kept", pcs[i]);
    endtask

    initial begin
        void'($urandom(32'hb742));
        clk         = 1'b0;
        rst         = 1'b1;
        exe         = '0;
        fetch_stall = 1'b1;
        btb_head    = 0;
        jtb_head    = 0;
        for (int i = 0; i < `BTB_ENTRIES; i++)
            btb_valid[i] = 1'b0;
        for (int j = 0; j < `JTB_ENTRIES; j++)
            jtb_valid[j] = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        sequential_fetch();
        jump_learning();
        branch_histories();
        mispredict_redirect();
        stall_holding();
        btb_eviction();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : branch_predict_tb

/* files.f */
+incdir+common
common/bp_pkg.sv
predictor/btb_entry.sv
predictor/jtb_entry.sv
predictor/control_buffer.sv
hdl/resolve_capture.sv
hdl/next_pc_select.sv
hdl/branch_predict_top.sv
tb/branch_predict_assert.sv
tb/branch_predict_tb.sv

/* run.sh */
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module branch_predict_tb -o branch_predict_sim

./obj_dir/branch_predict_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
